//--- verilog/rv_core_pkg.sv
// RV32I integer subset only (R-type ALU, OP-IMM, LUI); no PC, memory, branch or CSR support
`default_nettype none

package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // The decoder accepts only these major opcodes and drops anything else as a bubble
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // Bit 1 picks the newer pending result, bit 0 the older one
    typedef enum logic [1:0] {
        FWD_RF  = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } fwd_sel_e;

    // Decoded operation handed from decode to execute
    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rf_en;
        logic                  use_imm;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
    } dec_op_t;

    // A result waiting in the execute pipeline or leaving it
    typedef struct packed {
        logic                  valid;
        logic                  rf_en;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } result_t;

endpackage

`default_nettype wire

//--- verilog/reg_file.sv
// Reset clears all 32 entries; reads are combinational and see a same-cycle write through the bypass
`default_nettype none
`timescale 1ns/10ps

module reg_file import rv_core_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wire  [REG_ADDR_W-1:0] rd_addr1_i,
    input  wire  [REG_ADDR_W-1:0] rd_addr2_i,
    input  wire  result_t         wr_i,
    output logic [XLEN-1:0]       rd_data1_o,
    output logic [XLEN-1:0]       rd_data2_o
);

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            wr_en;

    // x0 is never written, so it keeps the zero it got at reset
    assign wr_en = wr_i.valid && wr_i.rf_en && (wr_i.rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_i.rd] <= wr_i.data;
        end
    end

    // The writing instruction is three slots ahead of the reader, so bypass it here
    assign rd_data1_o = (wr_en && (wr_i.rd == rd_addr1_i)) ? wr_i.data : regs[rd_addr1_i];
    assign rd_data2_o = (wr_en && (wr_i.rd == rd_addr2_i)) ? wr_i.data : regs[rd_addr2_i];

    a_x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
        ((rd_addr1_i != '0) || (rd_data1_o == '0)) &&
        ((rd_addr2_i != '0) || (rd_data2_o == '0)));

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
// Accepts one instruction per cycle with no back-pressure; unsupported encodings leave as bubbles
`default_nettype none
`timescale 1ns/10ps

module decode_stage import rv_core_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wire                   instr_valid_i,
    input  wire  [XLEN-1:0]       instr_i,
    output logic [REG_ADDR_W-1:0] rf_addr1_o,
    output logic [REG_ADDR_W-1:0] rf_addr2_o,
    input  wire  [XLEN-1:0]       rf_data1_i,
    input  wire  [XLEN-1:0]       rf_data2_i,
    output dec_op_t               dec_o
);

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;

    opcode_e       opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    alu_op_e       base_op;
    alu_op_e       alu_op;
    logic          legal;
    logic          use_imm;
    logic [XLEN-1:0] imm;
    dec_op_t       dec_d;
    dec_op_t       dec_q;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign rf_addr1_o = instr_i[19:15];
    assign rf_addr2_o = instr_i[24:20];

    // The operation follows from funct3, and funct7 only ever turns it into SUB or SRA
    always_comb begin
        case (funct3)
            F3_ADD_SUB: base_op = ALU_ADD;
            F3_SLL:     base_op = ALU_SLL;
            F3_SLT:     base_op = ALU_SLT;
            F3_SLTU:    base_op = ALU_SLTU;
            F3_XOR:     base_op = ALU_XOR;
            F3_SRL_SRA: base_op = ALU_SRL;
            F3_OR:      base_op = ALU_OR;
            F3_AND:     base_op = ALU_AND;
        endcase
    end

    always_comb begin
        legal   = 1'b0;
        alu_op  = base_op;
        use_imm = 1'b0;
        imm     = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
        case (opcode)
            OPC_OP: begin
                if (funct7 == F7_BASE) begin
                    legal = 1'b1;
                end else if (funct7 == F7_ALT) begin
                    legal  = (funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA);
                    alu_op = (funct3 == F3_ADD_SUB) ? ALU_SUB : ALU_SRA;
                end
            end
            OPC_OP_IMM: begin
                use_imm = 1'b1;
                if (funct3 == F3_SLL) begin
                    legal = (funct7 == F7_BASE);
                end else if (funct3 == F3_SRL_SRA) begin
                    legal  = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                    alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                end else begin
                    legal = 1'b1;
                end
            end
            OPC_LUI: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                alu_op  = ALU_PASS_B;
                imm     = {instr_i[31:12], 12'b0};
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    always_comb begin
        dec_d.valid    = instr_valid_i && legal;
        dec_d.alu_op   = alu_op;
        dec_d.rs1      = rf_addr1_o;
        dec_d.rs2      = rf_addr2_o;
        dec_d.rd       = instr_i[11:7];
        dec_d.rf_en    = legal;
        dec_d.use_imm  = use_imm;
        dec_d.imm      = imm;
        dec_d.rs1_data = rf_data1_i;
        dec_d.rs2_data = rf_data2_i;
    end

    // Pipeline register towards execute
    always_ff @(posedge clk) begin
        dec_q <= dec_d;
        if (!rst_n_i) begin
            dec_q.valid <= 1'b0;
        end
    end

    assign dec_o = dec_q;

    a_valid_has_known_opcode: assert property (@(posedge clk) disable iff (!rst_n_i)
        dec_q.valid |-> $past(instr_valid_i) &&
                        ($past(instr_i[6:0]) inside {OPC_OP, OPC_OP_IMM, OPC_LUI}));

endmodule

`default_nettype wire

//--- verilog/fwd_unit.sv
// Purely combinational; the newer pending result wins over the older one, and x0 is never forwarded
`default_nettype none
`timescale 1ns/10ps

module fwd_unit import rv_core_pkg::*; (
    input  wire  [REG_ADDR_W-1:0] rs1_i,
    input  wire  [REG_ADDR_W-1:0] rs2_i,
    input  wire  result_t         mem_res_i,
    input  wire  result_t         wb_res_i,
    output fwd_sel_e              fwd1_o,
    output fwd_sel_e              fwd2_o
);

    function automatic fwd_sel_e pick_src(logic [REG_ADDR_W-1:0] rs,
                                          result_t mem_res, result_t wb_res);
        fwd_sel_e sel;
        sel = FWD_RF;
        if (mem_res.valid && mem_res.rf_en && (mem_res.rd != '0) && (mem_res.rd == rs)) begin
            sel = FWD_MEM;
        end else if (wb_res.valid && wb_res.rf_en && (wb_res.rd != '0) && (wb_res.rd == rs)) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    assign fwd1_o = pick_src(rs1_i, mem_res_i, wb_res_i);
    assign fwd2_o = pick_src(rs2_i, mem_res_i, wb_res_i);

endmodule

`default_nettype wire

//--- verilog/alu.sv
// Combinational RV32I integer ALU; shift amounts use only the low five bits of b
`default_nettype none
`timescale 1ns/10ps

module alu import rv_core_pkg::*; (
    input  alu_op_e         op_i,
    input  wire  [XLEN-1:0] a_i,
    input  wire  [XLEN-1:0] b_i,
    output logic [XLEN-1:0] res_o
);

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD: begin
                res_o = a_i + b_i;
            end
            ALU_SUB: begin
                res_o = a_i - b_i;
            end
            ALU_SLL: begin
                res_o = a_i << shamt;
            end
            ALU_SLT: begin
                res_o = {{(XLEN-1){1'b0}}, ($signed(a_i) < $signed(b_i))};
            end
            ALU_SLTU: begin
                res_o = {{(XLEN-1){1'b0}}, (a_i < b_i)};
            end
            ALU_XOR: begin
                res_o = a_i ^ b_i;
            end
            ALU_SRL: begin
                res_o = a_i >> shamt;
            end
            ALU_SRA: begin
                res_o = $unsigned($signed(a_i) >>> shamt);
            end
            ALU_OR: begin
                res_o = a_i | b_i;
            end
            ALU_AND: begin
                res_o = a_i & b_i;
            end
            // LUI carries its shifted immediate on b
            ALU_PASS_B: begin
                res_o = b_i;
            end
            default: begin
                res_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/exec_stage.sv
// Two result registers follow the ALU; the older one is the retire and register-file write port
`default_nettype none
`timescale 1ns/10ps

module exec_stage import rv_core_pkg::*; (
    input  wire      clk,
    input  wire      rst_n_i,
    input  dec_op_t  dec_i,
    input  fwd_sel_e fwd1_i,
    input  fwd_sel_e fwd2_i,
    output result_t  mem_res_o,
    output result_t  wb_res_o
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    result_t         mem_d;
    result_t         mem_q;
    result_t         wb_d;
    result_t         wb_q;

    function automatic logic [XLEN-1:0] operand(fwd_sel_e sel, logic [XLEN-1:0] rf_val,
                                                result_t mem_res, result_t wb_res);
        logic [XLEN-1:0] val;
        case (sel)
            FWD_MEM: val = mem_res.data;
            FWD_WB:  val = wb_res.data;
            default: val = rf_val;
        endcase
        return val;
    endfunction

    assign op_a    = operand(fwd1_i, dec_i.rs1_data, mem_q, wb_q);
    assign rs2_val = operand(fwd2_i, dec_i.rs2_data, mem_q, wb_q);
    assign op_b    = dec_i.use_imm ? dec_i.imm : rs2_val;

    alu u_alu (
        .op_i  (dec_i.alu_op),
        .a_i   (op_a),
        .b_i   (op_b),
        .res_o (alu_res)
    );

    always_comb begin
        mem_d.valid = dec_i.valid;
        mem_d.rf_en = dec_i.rf_en;
        mem_d.rd    = dec_i.rd;
        mem_d.data  = alu_res;
    end

    // A write to x0 still retires, but shows zero like the register does
    always_comb begin
        wb_d      = mem_q;
        wb_d.data = (mem_q.rd == '0) ? '0 : mem_q.data;
    end

    always_ff @(posedge clk) begin
        mem_q <= mem_d;
        wb_q  <= wb_d;
        if (!rst_n_i) begin
            mem_q.valid <= 1'b0;
            wb_q.valid  <= 1'b0;
        end
    end

    assign mem_res_o = mem_q;
    assign wb_res_o  = wb_q;

    // Every supported instruction writes a register, so rf_en must follow valid
    a_valid_writes_rf: assert property (@(posedge clk) disable iff (!rst_n_i)
        (mem_q.valid |-> mem_q.rf_en) and (wb_q.valid |-> wb_q.rf_en));

endmodule

`default_nettype wire

//--- verilog/core_top.sv
// Three-stage RV32I integer core; an accepted instruction retires three clock edges later, in order
`default_nettype none
`timescale 1ns/10ps

module core_top import rv_core_pkg::*; (
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wire                   instr_valid_i,
    input  wire  [XLEN-1:0]       instr_i,
    output logic                  retire_valid_o,
    output logic [REG_ADDR_W-1:0] retire_rd_o,
    output logic [XLEN-1:0]       retire_data_o
);

    logic [REG_ADDR_W-1:0] rf_addr1;
    logic [REG_ADDR_W-1:0] rf_addr2;
    logic [XLEN-1:0]       rf_data1;
    logic [XLEN-1:0]       rf_data2;
    dec_op_t               dec_op;
    fwd_sel_e              fwd1;
    fwd_sel_e              fwd2;
    result_t               mem_res;
    result_t               wb_res;

    decode_stage u_decode (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rf_addr1_o    (rf_addr1),
        .rf_addr2_o    (rf_addr2),
        .rf_data1_i    (rf_data1),
        .rf_data2_i    (rf_data2),
        .dec_o         (dec_op)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rd_addr1_i (rf_addr1),
        .rd_addr2_i (rf_addr2),
        .wr_i       (wb_res),
        .rd_data1_o (rf_data1),
        .rd_data2_o (rf_data2)
    );

    fwd_unit u_fwd (
        .rs1_i     (dec_op.rs1),
        .rs2_i     (dec_op.rs2),
        .mem_res_i (mem_res),
        .wb_res_i  (wb_res),
        .fwd1_o    (fwd1),
        .fwd2_o    (fwd2)
    );

    exec_stage u_exec (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .dec_i     (dec_op),
        .fwd1_i    (fwd1),
        .fwd2_i    (fwd2),
        .mem_res_o (mem_res),
        .wb_res_o  (wb_res)
    );

    assign retire_valid_o = wb_res.valid;
    assign retire_rd_o    = wb_res.rd;
    assign retire_data_o  = wb_res.data;

endmodule

`default_nettype wire

//--- tests/tb_core_top.sv
// Directed tests for core_top; results come from a reference register model and retire 3 edges late
`default_nettype none
`timescale 1ns/10ps

module tb_core_top import rv_core_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 3;
    localparam int RETIRE_LAT   = 3;
    localparam int DRAIN_LIMIT  = 8;
    localparam int N_IDLE_RESET = 5;
    localparam int N_IMM        = 40;
    localparam int N_PRELOAD    = 16;
    localparam int N_RSEQ       = 40;
    localparam int N_X0         = 6;
    localparam int N_BUBBLE     = 12;
    localparam int TOTAL_SLOTS  = RESET_CYCLES + N_IDLE_RESET + 1 + N_IMM + 2 * N_PRELOAD +
                                  N_RSEQ + N_X0 + N_BUBBLE;
    localparam int WATCHDOG_NS  = (TOTAL_SLOTS + 50) * CLK_PERIOD;

    // funct7 and funct3 of ADD SUB SLL SLT SLTU XOR SRL SRA OR AND, in that order
    localparam logic [6:0] R_F7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
                                         7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
    localparam logic [2:0] R_F3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                         3'd4, 3'd5, 3'd5, 3'd6, 3'd7};

    typedef struct packed {
        logic [31:0]           accept_edge;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } retire_exp_t;

    logic                  clk = 1'b0;
    logic                  rst_n_i;
    logic                  instr_valid_i;
    logic [XLEN-1:0]       instr_i;
    logic                  retire_valid_o;
    logic [REG_ADDR_W-1:0] retire_rd_o;
    logic [XLEN-1:0]       retire_data_o;

    logic [XLEN-1:0] ref_regs [NUM_REGS];
    retire_exp_t     exp_q [$];
    logic [31:0]     edge_cnt;
    logic [31:0]     rng_state;
    int              err_cnt;
    int              check_cnt;

    core_top DUT (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .retire_valid_o (retire_valid_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] reg_op_word(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                                logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] imm_op_word(logic [11:0] imm, logic [4:0] rs1,
                                                logic [2:0] f3, logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_word(logic [19:0] imm, logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // Applies one instruction to the reference registers, returns 0 when the core must drop it
    function automatic bit model_step(logic [31:0] instr, output logic [4:0] rd,
                                      output logic [31:0] value);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        bit          alt;
        bit          legal;
        opc   = instr[6:0];
        f3    = instr[14:12];
        f7    = instr[31:25];
        rd    = instr[11:7];
        a     = ref_regs[instr[19:15]];
        b     = ref_regs[instr[24:20]];
        alt   = 1'b0;
        legal = 1'b0;
        value = '0;
        if (opc == 7'b0110011) begin
            alt   = (f7 == 7'h20);
            legal = (f7 == 7'h00) || (alt && (f3 == 3'd0 || f3 == 3'd5));
        end else if (opc == 7'b0010011) begin
            // OP-IMM has no subtract, so alt only marks SRAI
            b     = {{20{instr[31]}}, instr[31:20]};
            alt   = (f3 == 3'd5) && (f7 == 7'h20);
            legal = (f3 == 3'd1) ? (f7 == 7'h00) : (f3 == 3'd5) ? (f7 == 7'h00 || alt) : 1'b1;
        end
        if (legal) begin
            case (f3)
                3'd0: value = alt ? a - b : a + b;
                3'd1: value = a << b[4:0];
                3'd2: value = {31'b0, $signed(a) < $signed(b)};
                3'd3: value = {31'b0, a < b};
                3'd4: value = a ^ b;
                3'd5: value = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'd6: value = a | b;
                default: value = a & b;
            endcase
        end
        if (opc == 7'b0110111) begin
            legal = 1'b1;
            value = {instr[31:12], 12'h000};
        end
        if (legal && rd != 5'd0) begin
            ref_regs[rd] = value;
        end else begin
            value = '0;
        end
        return legal;
    endfunction

    task automatic issue(logic [31:0] instr);
        retire_exp_t exp;
        logic [4:0]  rd;
        logic [31:0] value;
        bit          legal;
        @(negedge clk);
        instr_valid_i = 1'b1;
        instr_i       = instr;
        legal         = model_step(instr, rd, value);
        if (legal) begin
            exp.accept_edge = edge_cnt + 32'd1;
            exp.rd          = rd;
            exp.data        = value;
            exp_q.push_back(exp);
        end
    endtask

    // Random words sit on instr_i while the strobe is low and must be ignored
    task automatic idle(int cycles);
        repeat (cycles) begin
            @(negedge clk);
            instr_valid_i = 1'b0;
            instr_i       = next_rand();
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        idle(1);
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0t: %0d expected retires never appeared", $time, exp_q.size());
            err_cnt++;
            exp_q.delete();
        end
    endtask

    task automatic report_test(string name, int errs_before);
        $display("Test %s done, %0d errors", name, err_cnt - errs_before);
    endtask

    // Outputs are sampled at the rising edge before the DUT updates them
    always @(posedge clk) begin
        retire_exp_t exp;
        edge_cnt = edge_cnt + 32'd1;
        if (rst_n_i) begin
            if (retire_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("%0t: unexpected retire of x%0d", $time, retire_rd_o);
                    err_cnt++;
                end else begin
                    exp = exp_q.pop_front();
                    check_cnt++;
                    if (retire_rd_o !== exp.rd) begin
                        $display("[ERROR] t=%0t retire_rd_o expected %0d got %0d",
                                 $time, exp.rd, retire_rd_o);
                        err_cnt++;
                    end
                    if (retire_data_o !== exp.data) begin
                        $display("[ERROR] t=%0t retire_data_o expected 0x%08h got 0x%08h",
                                 $time, exp.data, retire_data_o);
                        err_cnt++;
                    end
                    if (edge_cnt != exp.accept_edge + RETIRE_LAT) begin
                        $display("%0t: retire of x%0d at edge %0d, due at edge %0d", $time,
                                 exp.rd, edge_cnt, exp.accept_edge + RETIRE_LAT);
                        err_cnt++;
                    end
                end
            end else if (exp_q.size() != 0 && edge_cnt >= exp_q[0].accept_edge + RETIRE_LAT) begin
                $display("%0t: retire of x%0d is missing", $time, exp_q[0].rd);
                err_cnt++;
                exp = exp_q.pop_front();
            end
        end
    end

    task automatic reset_idle();
        int errs_before;
        errs_before = err_cnt;
        repeat (N_IDLE_RESET) begin
            @(negedge clk);
            check_cnt++;
            if (retire_valid_o !== 1'b0) begin
                $display("[ERROR] t=%0t retire_valid_o expected 0 got %b", $time, retire_valid_o);
                err_cnt++;
            end
        end
        // ADD x5, x1, x2 on a freshly cleared register file
        issue(reg_op_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd5));
        drain();
        report_test("reset_idle", errs_before);
    endtask

    task automatic imm_and_lui();
        int          errs_before;
        logic [31:0] r;
        logic [31:0] u;
        logic [11:0] imm;
        errs_before = err_cnt;
        for (int k = 0; k < N_IMM; k++) begin
            r   = next_rand();
            u   = next_rand();
            imm = r[27:16];
            if (r[31:29] == 3'd0) begin
                issue(lui_word(u[31:12], r[7:3]));
            end else begin
                if (r[15:13] == 3'd1) begin
                    imm[11:5] = 7'h00;
                end else if (r[15:13] == 3'd5) begin
                    imm[11:5] = r[28] ? 7'h20 : 7'h00;
                end
                issue(imm_op_word(imm, r[12:8], r[15:13], r[7:3]));
            end
        end
        drain();
        report_test("imm_and_lui", errs_before);
    endtask

    // Sources trail the destination by 1 to 4 slots, covering both forwards and the bypass
    task automatic reg_chain();
        int          errs_before;
        int          d1;
        int          d2;
        logic [31:0] u;
        errs_before = err_cnt;
        for (int r = 0; r < N_PRELOAD; r++) begin
            u = next_rand();
            issue(lui_word(u[31:12], 5'(8 + r)));
            issue(imm_op_word(u[11:0], 5'(8 + r), 3'd0, 5'(8 + r)));
        end
        for (int k = 0; k < N_RSEQ; k++) begin
            d1 = 1 + (k % 4);
            d2 = 1 + ((k + 2) % 4);
            issue(reg_op_word(R_F7[4'(k % 10)], 5'(8 + ((k + 16 - d2) % 16)),
                              5'(8 + ((k + 16 - d1) % 16)), R_F3[4'(k % 10)], 5'(8 + (k % 16))));
        end
        drain();
        report_test("reg_chain", errs_before);
    endtask

    task automatic x0_writes();
        int errs_before;
        errs_before = err_cnt;
        issue(imm_op_word(12'h07b, 5'd8, 3'd0, 5'd0));
        issue(reg_op_word(7'h00, 5'd9, 5'd8, 3'd0, 5'd0));
        issue(lui_word(20'habcde, 5'd0));
        issue(reg_op_word(7'h00, 5'd0, 5'd0, 3'd0, 5'd6));
        issue(imm_op_word(12'h005, 5'd0, 3'd0, 5'd7));
        issue(reg_op_word(7'h00, 5'd0, 5'd7, 3'd6, 5'd6));
        drain();
        report_test("x0_writes", errs_before);
    endtask

    task automatic bubbles_and_gaps();
        int errs_before;
        errs_before = err_cnt;
        issue(imm_op_word(12'd77, 5'd0, 3'd0, 5'd9));
        // SW x9, 4(x1)
        issue({7'h00, 5'd9, 5'd1, 3'b010, 5'd4, 7'b0100011});
        issue(imm_op_word(12'd1, 5'd9, 3'd0, 5'd10));
        idle(1);
        // BEQ x9, x9, +8 and JAL x1, 0
        issue({7'h00, 5'd9, 5'd9, 3'b000, 5'd8, 7'b1100011});
        issue({20'h00000, 5'd1, 7'b1101111});
        issue(reg_op_word(7'h00, 5'd9, 5'd10, 3'd0, 5'd11));
        idle(1);
        // MUL is outside RV32I
        issue(reg_op_word(7'h01, 5'd9, 5'd9, 3'd0, 5'd4));
        issue(reg_op_word(7'h20, 5'd9, 5'd11, 3'd0, 5'd12));
        // AUIPC x3
        issue({20'h12345, 5'd3, 7'b0010111});
        issue(reg_op_word(7'h00, 5'd10, 5'd12, 3'd4, 5'd13));
        drain();
        report_test("bubbles_and_gaps", errs_before);
    endtask

    initial begin
        rng_state     = 32'd42;
        edge_cnt      = '0;
        err_cnt       = 0;
        check_cnt     = 0;
        ref_regs      = '{default: '0};
        rst_n_i       = 1'b0;
        // A legal ADDI x1, x0, 1 is offered during reset and must never retire
        instr_valid_i = 1'b1;
        instr_i       = imm_op_word(12'd1, 5'd0, 3'd0, 5'd1);
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_i       = 1'b1;
        instr_valid_i = 1'b0;
        reset_idle();
        imm_and_lui();
        reg_chain();
        x0_writes();
        bubbles_and_gaps();
        $display("Done: 5 tests, %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the tests did not complete", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
verilog/rv_core_pkg.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/fwd_unit.sv
verilog/alu.sv
verilog/exec_stage.sv
verilog/core_top.sv
tests/tb_core_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the core testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_core

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_core_top -f flist.f -o "$BIN"
if [ $? -ne 0 ]; then
    echo "run_sim: build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "run_sim: failures reported, see $LOG"
    exit 1
fi

echo "run_sim: no failures in $LOG"
exit 0
